// ==== source/cart_bus_pkg.sv ====
`default_nettype none

package cart_bus_pkg;

    // Z80 side of the cartridge slot
    parameter int cpu_addr_w = 16;
    parameter int cpu_data_w = 8;

    // Flat ROM space behind the mapper, 128 MB of byte addresses
    parameter int rom_addr_w = 27;

    // ROM size in bytes, up to 32 MB
    parameter int rom_size_w = 25;

    // Bank entry: bit 8 marks an unmapped page, bits 7:0 hold the block
    parameter int bank_entry_w = 9;

    parameter logic [bank_entry_w-1:0] bank_unmapped = 9'h100;

endpackage

`default_nettype wire

// ==== source/mapper_pkg.sv ====
`default_nettype none

package mapper_pkg;

    // Mapper families known to the slot configuration
    typedef enum logic [3:0] {
        mapper_none        = 4'd0,
        mapper_generic8kb  = 4'd1,
        mapper_generic16kb = 4'd2
    } mapper_type_t;

    // The 64 KB CPU space splits into eight 8 KB pages
    parameter int page_count = 8;

    // Byte offset bits inside one 8 KB page
    parameter int page_offset_w = 13;

    // Bank select writes land in 4000h up to, but not including, C000h
    parameter logic [15:0] bank_window_lo = 16'h4000;
    parameter logic [15:0] bank_window_hi = 16'hC000;

endpackage

`default_nettype wire

// ==== source/cart_bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_bus_decoder
    import cart_bus_pkg::*, mapper_pkg::*;
#(
    parameter int num_slots = 2,
    localparam int slot_w = (num_slots > 1) ? $clog2(num_slots) : 1,
    localparam int page_w = $clog2(page_count)
) (
    input  wire logic                    clock_bus,
    input  wire logic                    rst_n,
    input  wire logic                    ce_3m58_p,
    input  wire logic                    mreq,
    input  wire logic                    wr,
    input  wire logic [cpu_addr_w-1:0]   addr,
    input  wire logic [cpu_data_w-1:0]   data,
    input  wire logic [slot_w-1:0]       slot_id,
    input  mapper_type_t                 mapper_type,
    input  wire logic [rom_size_w-1:0]   rom_size,
    output logic                         map_sel,
    output logic                         bank_we,
    output logic [slot_w-1:0]            bank_wr_slot,
    output logic [page_w-1:0]            bank_wr_page,
    output logic                         bank_wr_pair,
    output logic [bank_entry_w-1:0]      bank_wr_entry
);

    logic       is_16kb;
    logic       in_window;
    logic [7:0] nr_blocks;
    logic [7:0] block_mask;
    logic [7:0] block;
    logic       active_q;

    // Only the generic types respond on the bus
    assign map_sel = ((mapper_type == mapper_generic8kb) ||
                      (mapper_type == mapper_generic16kb)) && mreq;

    assign is_16kb   = (mapper_type == mapper_generic16kb);
    assign in_window = (addr >= bank_window_lo) && (addr < bank_window_hi);

    // Writes only count on the 3.58 MHz enable pulse
    assign bank_we = map_sel && wr && in_window && ce_3m58_p;

    // Number of blocks in the ROM, truncated to a byte as the hardware does
    assign nr_blocks = is_16kb ? 8'(rom_size >> (page_offset_w + 1))
                               : 8'(rom_size >> page_offset_w);
    assign block_mask = nr_blocks - 8'd1;

    // Out of range block numbers wrap through the mask first
    assign block = (data < nr_blocks) ? data : (data & block_mask);

    // Still out of range after the mask, e.g. for non power of two sizes
    assign bank_wr_entry = (block < nr_blocks) ? {1'b0, block} : bank_unmapped;

    assign bank_wr_slot = slot_id;
    assign bank_wr_pair = is_16kb;

    // A 16 KB page always starts on the even 8 KB half
    assign bank_wr_page = is_16kb ? {addr[cpu_addr_w-1 -: 2], 1'b0}
                                  : addr[cpu_addr_w-1 -: page_w];

    // High from the first cycle after reset is released
    always_ff @(posedge clock_bus) begin
        if (!rst_n) begin
            active_q <= 1'b0;
        end else begin
            active_q <= 1'b1;
        end
    end

    a_we_needs_sel_wr: assert property (
        @(posedge clock_bus) disable iff (!active_q)
        bank_we |-> (map_sel && wr)
    );

endmodule

`default_nettype wire

// ==== source/bank_register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_register_file
    import cart_bus_pkg::*, mapper_pkg::*;
#(
    parameter int num_slots = 2,
    localparam int slot_w = (num_slots > 1) ? $clog2(num_slots) : 1,
    localparam int page_w = $clog2(page_count)
) (
    input  wire logic                    clock_bus,
    input  wire logic                    rst_n,
    input  wire logic                    bank_we,
    input  wire logic [slot_w-1:0]       bank_wr_slot,
    input  wire logic [page_w-1:0]       bank_wr_page,
    input  wire logic                    bank_wr_pair,
    input  wire logic [bank_entry_w-1:0] bank_wr_entry,
    input  wire logic [slot_w-1:0]       rd_slot,
    input  wire logic [page_w-1:0]       rd_page,
    output logic [bank_entry_w-1:0]      rd_entry
);

    logic [bank_entry_w-1:0] bank [num_slots][page_count];
    logic [page_w-1:0]       even_page;
    logic [page_w-1:0]       odd_page;
    logic                    rst_seen;

    // Power-on layout: pages 2 to 5 show blocks 0 to 3, the rest is unmapped
    function automatic logic [bank_entry_w-1:0] reset_entry(input int page);
        if ((page >= 2) && (page <= 5)) begin
            return bank_entry_w'(page - 2);
        end
        return bank_unmapped;
    endfunction

    assign even_page = {bank_wr_page[page_w-1:1], 1'b0};
    assign odd_page  = {bank_wr_page[page_w-1:1], 1'b1};

    always_ff @(posedge clock_bus) begin
        if (!rst_n) begin
            for (int s = 0; s < num_slots; s++) begin
                for (int p = 0; p < page_count; p++) begin
                    bank[s][p] <= reset_entry(p);
                end
            end
        end else if (bank_we) begin
            if (bank_wr_pair) begin
                // 16 KB mapper: both halves get the same block
                bank[bank_wr_slot][even_page] <= bank_wr_entry;
                bank[bank_wr_slot][odd_page]  <= bank_wr_entry;
            end else begin
                bank[bank_wr_slot][bank_wr_page] <= bank_wr_entry;
            end
        end
    end

    // Read port is combinational, so a write shows up on the next cycle
    assign rd_entry = bank[rd_slot][rd_page];

    always_ff @(posedge clock_bus) begin
        if (!rst_n) begin
            rst_seen <= 1'b0;
        end else begin
            rst_seen <= 1'b1;
        end
    end

    // The decoder must hand over an even page whenever it asks for a pair
    a_pair_even: assert property (
        @(posedge clock_bus) disable iff (!rst_seen)
        (bank_we && bank_wr_pair) |-> !bank_wr_page[0]
    );

    a_slot_range: assert property (
        @(posedge clock_bus) disable iff (!rst_seen)
        bank_we |-> (int'(bank_wr_slot) < num_slots)
    );

endmodule

`default_nettype wire

// ==== source/rom_address_translator.sv ====
`timescale 1ns/1ps
`default_nettype none

module rom_address_translator
    import cart_bus_pkg::*, mapper_pkg::*;
(
    input  wire logic                    map_sel,
    input  wire logic                    rd,
    input  wire logic [cpu_addr_w-1:0]   addr,
    input  mapper_type_t                 mapper_type,
    input  wire logic [rom_size_w-1:0]   rom_size,
    input  wire logic [bank_entry_w-1:0] rd_entry,
    output logic                         ram_cs,
    output logic [rom_addr_w-1:0]        ram_addr
);

    logic                  unmapped;
    logic [7:0]            block;
    logic [rom_addr_w-1:0] flat_8kb;
    logic [rom_addr_w-1:0] flat_16kb;
    logic [rom_addr_w-1:0] flat_addr;
    logic [rom_addr_w-1:0] rom_limit;
    logic                  in_range;

    assign {unmapped, block} = rd_entry;

    // Block number scaled by the page size, then the offset inside the page
    assign flat_8kb  = rom_addr_w'({block, addr[page_offset_w-1:0]});
    assign flat_16kb = rom_addr_w'({block, addr[page_offset_w:0]});

    assign flat_addr = (mapper_type == mapper_generic8kb) ? flat_8kb : flat_16kb;

    // Anything past the end of the image is treated as open bus
    assign rom_limit = rom_addr_w'(rom_size);
    assign in_range  = (flat_addr < rom_limit);

    assign ram_cs   = map_sel && rd && !unmapped && in_range;
    assign ram_addr = ram_cs ? flat_addr : '1;

    // Checked once the combinational inputs have settled
    always_comb begin
        if (ram_cs) begin
            a_cs_in_rom: assert final (ram_addr < rom_limit);
        end
    end

endmodule

`default_nettype wire

// ==== source/cart_mapper_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_mapper_top
    import cart_bus_pkg::*, mapper_pkg::*;
#(
    parameter int num_slots = 2,
    localparam int slot_w = (num_slots > 1) ? $clog2(num_slots) : 1,
    localparam int page_w = $clog2(page_count)
) (
    input  wire logic                  clock_bus,
    input  wire logic                  rst_n,
    input  wire logic                  ce_3m58_p,
    input  wire logic                  mreq,
    input  wire logic                  rd,
    input  wire logic                  wr,
    input  wire logic [cpu_addr_w-1:0] addr,
    input  wire logic [cpu_data_w-1:0] data,
    input  wire logic [slot_w-1:0]     slot_id,
    input  mapper_type_t               mapper_type,
    input  wire logic [rom_size_w-1:0] rom_size,
    output logic                       ram_cs,
    output logic [rom_addr_w-1:0]      ram_addr
);

    logic                    map_sel;
    logic                    bank_we;
    logic [slot_w-1:0]       bank_wr_slot;
    logic [page_w-1:0]       bank_wr_page;
    logic                    bank_wr_pair;
    logic [bank_entry_w-1:0] bank_wr_entry;
    logic [bank_entry_w-1:0] rd_entry;

    cart_bus_decoder #(
        .num_slots (num_slots)
    ) u_cart_bus_decoder (
        .clock_bus     (clock_bus),
        .rst_n         (rst_n),
        .ce_3m58_p     (ce_3m58_p),
        .mreq          (mreq),
        .wr            (wr),
        .addr          (addr),
        .data          (data),
        .slot_id       (slot_id),
        .mapper_type   (mapper_type),
        .rom_size      (rom_size),
        .map_sel       (map_sel),
        .bank_we       (bank_we),
        .bank_wr_slot  (bank_wr_slot),
        .bank_wr_page  (bank_wr_page),
        .bank_wr_pair  (bank_wr_pair),
        .bank_wr_entry (bank_wr_entry)
    );

    // Read side indexes the table by the current slot and the top address bits
    bank_register_file #(
        .num_slots (num_slots)
    ) u_bank_register_file (
        .clock_bus     (clock_bus),
        .rst_n         (rst_n),
        .bank_we       (bank_we),
        .bank_wr_slot  (bank_wr_slot),
        .bank_wr_page  (bank_wr_page),
        .bank_wr_pair  (bank_wr_pair),
        .bank_wr_entry (bank_wr_entry),
        .rd_slot       (slot_id),
        .rd_page       (addr[cpu_addr_w-1 -: page_w]),
        .rd_entry      (rd_entry)
    );

    rom_address_translator u_rom_address_translator (
        .map_sel     (map_sel),
        .rd          (rd),
        .addr        (addr),
        .mapper_type (mapper_type),
        .rom_size    (rom_size),
        .rd_entry    (rd_entry),
        .ram_cs      (ram_cs),
        .ram_addr    (ram_addr)
    );

endmodule

`default_nettype wire

// ==== testbench/cart_mapper_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_mapper_tb
    import cart_bus_pkg::*, mapper_pkg::*;
();

    localparam int          reset_cycles = 5;
    localparam int          max_cycles   = 20000;
    localparam logic [31:0] open_bus     = 32'h07FF_FFFF;

    logic                  clock_bus;
    logic                  rst_n;
    logic                  ce_3m58_p;
    logic                  mreq;
    logic                  rd;
    logic                  wr;
    logic [cpu_addr_w-1:0] addr;
    logic [cpu_data_w-1:0] data;
    logic [0:0]            slot_id;
    mapper_type_t          mapper_type;
    logic [rom_size_w-1:0] rom_size;
    logic                  ram_cs;
    logic [rom_addr_w-1:0] ram_addr;

    // Reference copy of both slot tables
    logic [bank_entry_w-1:0] model_bank [2][page_count];

    int error_count;
    int check_count;

    cart_mapper_top #(
        .num_slots (2)
    ) u_cart_mapper_top (
        .clock_bus   (clock_bus),
        .rst_n       (rst_n),
        .ce_3m58_p   (ce_3m58_p),
        .mreq        (mreq),
        .rd          (rd),
        .wr          (wr),
        .addr        (addr),
        .data        (data),
        .slot_id     (slot_id),
        .mapper_type (mapper_type),
        .rom_size    (rom_size),
        .ram_cs      (ram_cs),
        .ram_addr    (ram_addr)
    );

    initial begin
        clock_bus = 1'b0;
        forever #4 clock_bus = ~clock_bus;
    end

    function automatic logic is_generic(input mapper_type_t mt);
        return (mt == mapper_generic8kb) || (mt == mapper_generic16kb);
    endfunction

    // Block number after masking against the ROM size
    function automatic logic [bank_entry_w-1:0] clip_block(input logic [7:0] value,
                                                           input mapper_type_t mt,
                                                           input logic [rom_size_w-1:0] size);
        int         block_bytes;
        logic [7:0] nr;
        logic [7:0] blk;
        block_bytes = (mt == mapper_generic16kb) ? 16384 : 8192;
        nr = 8'((int'(size) / block_bytes) % 256);
        if (value < nr) begin
            blk = value;
        end else begin
            blk = value & (nr - 8'd1);
        end
        if (blk < nr) begin
            return {1'b0, blk};
        end
        return bank_unmapped;
    endfunction

    function automatic void reset_model();
        for (int s = 0; s < 2; s++) begin
            for (int p = 0; p < page_count; p++) begin
                model_bank[s][p] = ((p >= 2) && (p <= 5)) ? 9'(p - 2) : bank_unmapped;
            end
        end
    endfunction

    // Mirrors one bus write into the reference tables
    function automatic void model_write(input logic slot, input logic [15:0] a,
                                        input logic [7:0] d, input mapper_type_t mt,
                                        input logic [rom_size_w-1:0] size,
                                        input logic ce, input logic mreq_v);
        logic [2:0]              page;
        logic [bank_entry_w-1:0] entry;
        if (!(is_generic(mt) && mreq_v && ce && (a >= bank_window_lo) && (a < bank_window_hi))) begin
            return;
        end
        entry = clip_block(d, mt, size);
        if (mt == mapper_generic16kb) begin
            page = {a[15:14], 1'b0};
            model_bank[slot][page] = entry;
            model_bank[slot][page + 3'd1] = entry;
        end else begin
            page = a[15:13];
            model_bank[slot][page] = entry;
        end
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error: time %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic apply_reset();
        int n;
        @(posedge clock_bus);
        #1;
        rst_n = 1'b0;
        mreq = 1'b0;
        rd = 1'b0;
        wr = 1'b0;
        ce_3m58_p = 1'b0;
        n = 0;
        while (n < reset_cycles) begin
            @(posedge clock_bus);
            n++;
        end
        #1;
        rst_n = 1'b1;
        reset_model();
    endtask

    // One write cycle, taken by the DUT at the next rising edge
    task automatic do_write(input logic slot, input logic [15:0] a, input logic [7:0] d,
                            input mapper_type_t mt, input logic [rom_size_w-1:0] size,
                            input logic ce, input logic mreq_v);
        @(posedge clock_bus);
        #1;
        mreq = mreq_v;
        wr = 1'b1;
        rd = 1'b0;
        ce_3m58_p = ce;
        addr = a;
        data = d;
        slot_id = slot;
        mapper_type = mt;
        rom_size = size;
        model_write(slot, a, d, mt, size, ce, mreq_v);
    endtask

    task automatic do_read(input logic slot, input logic [15:0] a, input mapper_type_t mt,
                           input logic [rom_size_w-1:0] size, input logic mreq_v,
                           input logic rd_v);
        logic [bank_entry_w-1:0] entry;
        int                      flat;
        logic [31:0]             exp_cs;
        logic [31:0]             exp_addr;
        @(posedge clock_bus);
        #1;
        mreq = mreq_v;
        rd = rd_v;
        wr = 1'b0;
        ce_3m58_p = 1'b0;
        addr = a;
        slot_id = slot;
        mapper_type = mt;
        rom_size = size;
        @(negedge clock_bus);
        entry = model_bank[slot][a[15:13]];
        if (mt == mapper_generic16kb) begin
            flat = int'(entry[7:0]) * 16384 + int'(a[13:0]);
        end else begin
            flat = int'(entry[7:0]) * 8192 + int'(a[12:0]);
        end
        if (is_generic(mt) && mreq_v && rd_v && !entry[8] && (flat < int'(size))) begin
            exp_cs = 32'd1;
            exp_addr = 32'(flat);
        end else begin
            exp_cs = 32'd0;
            exp_addr = open_bus;
        end
        compare("ram_cs", 32'(ram_cs), exp_cs);
        compare("ram_addr", 32'(ram_addr), exp_addr);
    endtask

    task automatic read_all_pages(input logic slot, input mapper_type_t mt,
                                  input logic [rom_size_w-1:0] size);
        for (int p = 0; p < page_count; p++) begin
            do_read(slot, {3'(p), 13'($urandom)}, mt, size, 1'b1, 1'b1);
        end
    endtask

    function automatic logic [15:0] window_addr();
        return 16'(32'h4000 + ($urandom % 32'h8000));
    endfunction

    function automatic logic [15:0] outside_addr();
        if (($urandom % 2) == 0) begin
            return 16'($urandom % 32'h4000);
        end
        return 16'(32'hC000 + ($urandom % 32'h4000));
    endfunction

    function automatic mapper_type_t pick_mapper();
        case ($urandom % 3)
            0: return mapper_none;
            1: return mapper_generic8kb;
            default: return mapper_generic16kb;
        endcase
    endfunction

    // Stops a run that never reaches its end
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clock_bus);
            cycles++;
        end
        $display("timeout: simulation did not finish within %0d clock cycles", max_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [rom_size_w-1:0] odd_sizes [4];
        logic                  slot;
        mapper_type_t          mt;

        void'($urandom(32'h984a_701b));
        error_count = 0;
        check_count = 0;
        rst_n = 1'b0;
        ce_3m58_p = 1'b0;
        mreq = 1'b0;
        rd = 1'b0;
        wr = 1'b0;
        addr = '0;
        data = '0;
        slot_id = 1'b0;
        mapper_type = mapper_none;
        rom_size = '0;
        apply_reset();

        // Reset layout in both slots
        read_all_pages(1'b0, mapper_generic8kb, 25'h2_0000);
        read_all_pages(1'b1, mapper_generic8kb, 25'h2_0000);

        // 8 KB pages, 256 KB image
        repeat (40) begin
            slot = 1'($urandom % 2);
            do_write(slot, window_addr(), 8'($urandom), mapper_generic8kb, 25'h4_0000, 1'b1, 1'b1);
            read_all_pages(slot, mapper_generic8kb, 25'h4_0000);
        end

        // 16 KB pages, both halves follow one write
        repeat (40) begin
            slot = 1'($urandom % 2);
            do_write(slot, window_addr(), 8'($urandom), mapper_generic16kb, 25'h4_0000, 1'b1, 1'b1);
            read_all_pages(slot, mapper_generic16kb, 25'h4_0000);
        end

        // Sizes that are not a power of two, one of them truncating nr_blocks to zero
        odd_sizes[0] = 25'h0_B000;
        odd_sizes[1] = 25'h1_A000;
        odd_sizes[2] = 25'h20_1000;
        odd_sizes[3] = 25'h0_6000;
        for (int i = 0; i < 4; i++) begin
            repeat (10) begin
                slot = 1'($urandom % 2);
                do_write(slot, window_addr(), 8'($urandom), mapper_generic8kb, odd_sizes[i],
                         1'b1, 1'b1);
                read_all_pages(slot, mapper_generic8kb, odd_sizes[i]);
                do_write(slot, window_addr(), 8'($urandom), mapper_generic16kb, odd_sizes[i],
                         1'b1, 1'b1);
                read_all_pages(slot, mapper_generic16kb, odd_sizes[i]);
            end
        end

        // Writes that must be ignored
        for (int kind = 0; kind < 4; kind++) begin
            repeat (10) begin
                slot = 1'($urandom % 2);
                case (kind)
                    0: do_write(slot, outside_addr(), 8'($urandom), mapper_generic8kb,
                                25'h4_0000, 1'b1, 1'b1);
                    1: do_write(slot, window_addr(), 8'($urandom), mapper_generic8kb,
                                25'h4_0000, 1'b0, 1'b1);
                    2: do_write(slot, window_addr(), 8'($urandom), mapper_none,
                                25'h4_0000, 1'b1, 1'b1);
                    default: do_write(slot, window_addr(), 8'($urandom), mapper_generic8kb,
                                      25'h4_0000, 1'b1, 1'b0);
                endcase
                read_all_pages(1'b0, mapper_generic8kb, 25'h4_0000);
                read_all_pages(1'b1, mapper_generic8kb, 25'h4_0000);
            end
        end

        // Mixed traffic with random strobes, types and sizes
        repeat (300) begin
            slot = 1'($urandom % 2);
            mt = pick_mapper();
            if (($urandom % 2) == 0) begin
                do_write(slot, 16'($urandom), 8'($urandom), mt, rom_size_w'($urandom),
                         1'($urandom % 2), 1'($urandom % 2));
            end else begin
                do_read(slot, 16'($urandom), mt, rom_size_w'($urandom),
                        1'($urandom % 2), 1'($urandom % 2));
            end
        end

        // Slot 1 writes leave slot 0 alone, and a small image drops ram_cs past its end
        apply_reset();
        repeat (20) begin
            do_write(1'b1, window_addr(), 8'($urandom), mapper_generic8kb, 25'h4_0000, 1'b1, 1'b1);
            read_all_pages(1'b0, mapper_generic8kb, 25'h4_0000);
        end
        repeat (40) begin
            do_read(1'b0, 16'(32'h4000 + ($urandom % 32'h8000)), mapper_generic8kb, 25'h0_5000,
                    1'b1, 1'b1);
            do_read(1'b0, 16'(32'h4000 + ($urandom % 32'h8000)), mapper_generic16kb, 25'h0_5000,
                    1'b1, 1'b1);
        end

        @(posedge clock_bus);
        #1;
        mreq = 1'b0;
        rd = 1'b0;
        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cart_mapper_top.f ====
source/cart_bus_pkg.sv
source/mapper_pkg.sv
source/cart_bus_decoder.sv
source/bank_register_file.sv
source/rom_address_translator.sv
source/cart_mapper_top.sv
testbench/cart_mapper_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compiles the cartridge mapper testbench with Verilator, runs it,
# and decides pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

top=cart_mapper_tb
build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    -Mdir "$build_dir" \
    --top-module "$top" \
    -f cart_mapper_top.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$build_dir/V$top" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$log_file"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail, see $log_file"
    exit 1
fi
